// ==== rsa_defines.svh ====
`ifndef RSA_DEFINES_SVH
`define RSA_DEFINES_SVH

// operand width in bits
`define RSA_WIDTH 256

// AXI4-Lite bus widths
`define AXIL_ADDR_W 8
`define AXIL_DATA_W 32

// register map, byte offsets
`define RSA_REG_CTRL   8'h00
`define RSA_REG_STATUS 8'h04
// operands are eight words each, lsw first
`define RSA_REG_A      8'h10
`define RSA_REG_D      8'h30
`define RSA_REG_N      8'h50
`define RSA_REG_RESULT 8'h70

`endif

// ==== logic/rsa_pkg.sv ====
`default_nettype none

`include "rsa_defines.svh"

package rsa_pkg;

	// one operand or result
	typedef logic [`RSA_WIDTH-1:0] rsa_word_t;

	typedef enum logic [1:0] {
		ST_IDLE     = 2'b00,
		ST_PRESCALE = 2'b01,
		ST_MULTIPLY = 2'b10,
		ST_COMBINE  = 2'b11
	} rsa_state_t;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_t;

endpackage

`default_nettype wire

// ==== logic/rsa_prescale.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rsa_defines.svh"

module rsa_prescale import rsa_pkg::*; (
	input  wire logic      i_clk,
	input  wire logic      i_rst,
	input  wire logic      i_start,
	input  wire rsa_word_t i_a,
	input  wire rsa_word_t i_n,
	output rsa_word_t      o_t,
	output logic           o_done
);
	localparam int unsigned CW = $clog2(`RSA_WIDTH);

	logic                run;
	logic [CW-1:0]       cnt;
	logic                last;
	// value stays below 2N between steps
	logic [`RSA_WIDTH:0] t;
	logic [`RSA_WIDTH:0] t_red;

	assign last  = (cnt == CW'(`RSA_WIDTH - 1));
	assign t_red = (t >= {1'b0, i_n}) ? (t - {1'b0, i_n}) : t;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			run    <= 1'b0;
			cnt    <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				run <= 1'b1;
				cnt <= '0;
			end else if (run) begin
				if (last) begin
					run    <= 1'b0;
					o_done <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// start cycle already does the first doubling
	always_ff @(posedge i_clk) begin
		if (i_start) begin
			t <= {i_a, 1'b0};
		end else if (run) begin
			if (last) begin
				o_t <= t_red[`RSA_WIDTH-1:0];
			end else begin
				t <= {t_red[`RSA_WIDTH-1:0], 1'b0};
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/rsa_mont_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rsa_defines.svh"

module rsa_mont_mult import rsa_pkg::*; (
	input  wire logic      i_clk,
	input  wire logic      i_rst,
	input  wire logic      i_start,
	input  wire rsa_word_t i_x,
	input  wire rsa_word_t i_y,
	input  wire rsa_word_t i_n,
	output rsa_word_t      o_p,
	output logic           o_done
);
	localparam int unsigned IW = $clog2(`RSA_WIDTH);
	localparam int unsigned CW = IW + 1;

	logic                  run;
	logic [CW-1:0]         k;
	logic                  last;
	logic [IW-1:0]         bit_idx;
	// accumulator stays below 2N
	logic [`RSA_WIDTH:0]   acc;
	logic [`RSA_WIDTH:0]   acc_src;
	logic [`RSA_WIDTH:0]   acc_sub;
	logic [`RSA_WIDTH+1:0] sum_y;
	logic [`RSA_WIDTH+1:0] sum_n;

	assign last    = (k == CW'(`RSA_WIDTH));
	// step 0 runs in the start cycle from a cleared accumulator
	assign acc_src = i_start ? '0 : acc;
	assign bit_idx = i_start ? '0 : k[IW-1:0];
	assign sum_y   = {1'b0, acc_src} + (i_x[bit_idx] ? {2'b00, i_y} : '0);
	assign sum_n   = sum_y + (sum_y[0] ? {2'b00, i_n} : '0);
	assign acc_sub = acc - {1'b0, i_n};

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			run    <= 1'b0;
			k      <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				run <= 1'b1;
				k   <= CW'(1);
			end else if (run) begin
				if (last) begin
					run    <= 1'b0;
					o_done <= 1'b1;
				end else begin
					k <= k + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start || (run && !last)) begin
			acc <= sum_n[`RSA_WIDTH+1:1];
		end
		// final reduction into [0, N)
		if (run && last) begin
			o_p <= (acc >= {1'b0, i_n}) ? acc_sub[`RSA_WIDTH-1:0] : acc[`RSA_WIDTH-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== logic/rsa_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rsa_defines.svh"

module rsa_core import rsa_pkg::*; (
	input  wire logic      i_clk,
	input  wire logic      i_rst,
	input  wire logic      i_start,
	input  wire rsa_word_t i_a,
	input  wire rsa_word_t i_d,
	input  wire rsa_word_t i_n,
	output rsa_word_t      o_result,
	output logic           o_busy,
	output logic           o_done
);
	localparam int unsigned RW = $clog2(`RSA_WIDTH);

	rsa_state_t    state;
	rsa_state_t    state_nxt;
	logic [RW-1:0] round;
	logic [RW-1:0] round_nxt;
	logic          last_round;
	rsa_word_t     t;
	rsa_word_t     t_nxt;
	rsa_word_t     result;
	rsa_word_t     result_nxt;
	logic          pre_start;
	logic          pre_done;
	rsa_word_t     pre_t;
	logic          mont_start;
	logic          mul_done;
	rsa_word_t     mul_p;
	rsa_word_t     sqr_p;

	assign pre_start  = (state == ST_IDLE) && i_start;
	assign last_round = (round == RW'(`RSA_WIDTH - 1));
	assign o_busy     = (state != ST_IDLE);
	assign o_result   = result;

	always_comb begin
		state_nxt  = state;
		round_nxt  = round;
		t_nxt      = t;
		result_nxt = result;
		mont_start = 1'b0;
		case (state)
			ST_IDLE: begin
				if (i_start) begin
					state_nxt = ST_PRESCALE;
				end
			end
			ST_PRESCALE: begin
				if (pre_done) begin
					t_nxt      = pre_t;
					result_nxt = rsa_word_t'(1);
					round_nxt  = '0;
					mont_start = 1'b1;
					state_nxt  = ST_MULTIPLY;
				end
			end
			ST_MULTIPLY: begin
				// both units share the same latency
				if (mul_done) begin
					state_nxt = ST_COMBINE;
				end
			end
			ST_COMBINE: begin
				t_nxt = sqr_p;
				if (i_d[round]) begin
					result_nxt = mul_p;
				end
				if (last_round) begin
					state_nxt = ST_IDLE;
				end else begin
					round_nxt  = round + 1'b1;
					mont_start = 1'b1;
					state_nxt  = ST_MULTIPLY;
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state  <= ST_IDLE;
			round  <= '0;
			o_done <= 1'b0;
		end else begin
			state  <= state_nxt;
			round  <= round_nxt;
			o_done <= (state == ST_COMBINE) && last_round;
		end
	end

	always_ff @(posedge i_clk) begin
		t      <= t_nxt;
		result <= result_nxt;
	end

	rsa_prescale u_pre (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (pre_start),
		.i_a     (i_a),
		.i_n     (i_n),
		.o_t     (pre_t),
		.o_done  (pre_done)
	);

	// operands fed from next-state values so a round can start in the combine cycle
	rsa_mont_mult u_mul (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (mont_start),
		.i_x     (result_nxt),
		.i_y     (t_nxt),
		.i_n     (i_n),
		.o_p     (mul_p),
		.o_done  (mul_done)
	);

	rsa_mont_mult u_sqr (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (mont_start),
		.i_x     (t_nxt),
		.i_y     (t_nxt),
		.i_n     (i_n),
		.o_p     (sqr_p),
		.o_done  ()
	);

endmodule

`default_nettype wire

// ==== logic/rsa_axil_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rsa_defines.svh"

module rsa_axil_regs import rsa_pkg::*; (
	input  wire logic                       i_clk,
	input  wire logic                       i_rst,
	input  wire logic                       i_awvalid,
	output logic                            o_awready,
	input  wire logic [`AXIL_ADDR_W-1:0]    i_awaddr,
	input  wire logic                       i_wvalid,
	output logic                            o_wready,
	input  wire logic [`AXIL_DATA_W-1:0]    i_wdata,
	input  wire logic [`AXIL_DATA_W/8-1:0]  i_wstrb,
	output logic                            o_bvalid,
	input  wire logic                       i_bready,
	output axil_resp_t                      o_bresp,
	input  wire logic                       i_arvalid,
	output logic                            o_arready,
	input  wire logic [`AXIL_ADDR_W-1:0]    i_araddr,
	output logic                            o_rvalid,
	input  wire logic                       i_rready,
	output logic [`AXIL_DATA_W-1:0]         o_rdata,
	output axil_resp_t                      o_rresp,
	output logic                            o_start,
	output rsa_word_t                       o_a,
	output rsa_word_t                       o_d,
	output rsa_word_t                       o_n,
	input  wire logic                       i_busy,
	input  wire logic                       i_done,
	input  wire rsa_word_t                  i_result
);
	localparam int unsigned NW   = `RSA_WIDTH / `AXIL_DATA_W;
	localparam int unsigned NB   = `AXIL_DATA_W / 8;
	localparam int unsigned SPAN = NW * NB;
	localparam int unsigned XW   = $clog2(NW);

	logic                    aw_rdy;
	logic                    aw_hs;
	logic                    ar_hs;
	logic                    op_busy;
	logic                    wr_ok;
	logic                    wc_hit;
	logic                    wa_hit;
	logic                    wd_hit;
	logic                    wn_hit;
	logic                    done_q;
	rsa_word_t               a_q;
	rsa_word_t               d_q;
	rsa_word_t               n_q;
	rsa_word_t               result_q;
	logic [`AXIL_DATA_W-1:0] rdata_nxt;
	axil_resp_t              rresp_nxt;

	function automatic logic hit(input logic [`AXIL_ADDR_W-1:0] addr,
		input logic [`AXIL_ADDR_W-1:0] base);
		logic [`AXIL_ADDR_W-1:0] off;
		off = addr - base;
		return off < SPAN;
	endfunction

	function automatic logic [XW-1:0] widx(input logic [`AXIL_ADDR_W-1:0] addr,
		input logic [`AXIL_ADDR_W-1:0] base);
		logic [`AXIL_ADDR_W-1:0] off;
		off = addr - base;
		return off[XW+1:2];
	endfunction

	function automatic logic [`AXIL_DATA_W-1:0] pick(input rsa_word_t v,
		input logic [XW-1:0] idx);
		return v[idx*`AXIL_DATA_W +: `AXIL_DATA_W];
	endfunction

	// byte-strobed update of one operand word
	function automatic rsa_word_t merge(input rsa_word_t cur, input logic [XW-1:0] idx,
		input logic [`AXIL_DATA_W-1:0] data, input logic [NB-1:0] strb);
		rsa_word_t res;
		res = cur;
		for (int b = 0; b < NB; b++) begin
			if (strb[b]) begin
				res[idx*`AXIL_DATA_W + b*8 +: 8] = data[b*8 +: 8];
			end
		end
		return res;
	endfunction

	assign o_awready = aw_rdy;
	assign o_wready  = aw_rdy;
	assign aw_hs     = aw_rdy && i_awvalid && i_wvalid;
	assign ar_hs     = o_arready && i_arvalid;
	// start pulse counts as busy before the core reacts
	assign op_busy   = i_busy || o_start;
	assign wc_hit    = (i_awaddr == `RSA_REG_CTRL);
	assign wa_hit    = hit(i_awaddr, `RSA_REG_A);
	assign wd_hit    = hit(i_awaddr, `RSA_REG_D);
	assign wn_hit    = hit(i_awaddr, `RSA_REG_N);
	assign wr_ok     = aw_hs && !op_busy;
	assign o_a       = a_q;
	assign o_d       = d_q;
	assign o_n       = n_q;

	always_comb begin
		rdata_nxt = '0;
		rresp_nxt = RESP_OKAY;
		if (i_araddr == `RSA_REG_STATUS) begin
			rdata_nxt = {{(`AXIL_DATA_W-2){1'b0}}, done_q, op_busy};
		end else if (hit(i_araddr, `RSA_REG_A)) begin
			rdata_nxt = pick(a_q, widx(i_araddr, `RSA_REG_A));
		end else if (hit(i_araddr, `RSA_REG_D)) begin
			rdata_nxt = pick(d_q, widx(i_araddr, `RSA_REG_D));
		end else if (hit(i_araddr, `RSA_REG_N)) begin
			rdata_nxt = pick(n_q, widx(i_araddr, `RSA_REG_N));
		end else if (hit(i_araddr, `RSA_REG_RESULT)) begin
			rdata_nxt = pick(result_q, widx(i_araddr, `RSA_REG_RESULT));
		end else if (i_araddr != `RSA_REG_CTRL) begin
			rresp_nxt = RESP_SLVERR;
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			aw_rdy    <= 1'b0;
			o_bvalid  <= 1'b0;
			o_arready <= 1'b0;
			o_rvalid  <= 1'b0;
		end else begin
			aw_rdy    <= !aw_rdy && i_awvalid && i_wvalid && !o_bvalid;
			o_arready <= !o_arready && i_arvalid && !o_rvalid;
			if (aw_hs) begin
				o_bvalid <= 1'b1;
			end else if (o_bvalid && i_bready) begin
				o_bvalid <= 1'b0;
			end
			if (ar_hs) begin
				o_rvalid <= 1'b1;
			end else if (o_rvalid && i_rready) begin
				o_rvalid <= 1'b0;
			end
		end
	end

	// response payload held while valid waits
	always_ff @(posedge i_clk) begin
		if (aw_hs) begin
			o_bresp <= (wr_ok && (wc_hit || wa_hit || wd_hit || wn_hit)) ? RESP_OKAY : RESP_SLVERR;
		end
		if (ar_hs) begin
			o_rdata <= rdata_nxt;
			o_rresp <= rresp_nxt;
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			a_q      <= '0;
			d_q      <= '0;
			n_q      <= '0;
			result_q <= '0;
			o_start  <= 1'b0;
			done_q   <= 1'b0;
		end else begin
			o_start <= wr_ok && wc_hit && i_wdata[0];
			if (wr_ok && wa_hit) begin
				a_q <= merge(a_q, widx(i_awaddr, `RSA_REG_A), i_wdata, i_wstrb);
			end
			if (wr_ok && wd_hit) begin
				d_q <= merge(d_q, widx(i_awaddr, `RSA_REG_D), i_wdata, i_wstrb);
			end
			if (wr_ok && wn_hit) begin
				n_q <= merge(n_q, widx(i_awaddr, `RSA_REG_N), i_wdata, i_wstrb);
			end
			if (i_done) begin
				result_q <= i_result;
			end
			// done is sticky until the next start
			if (wr_ok && wc_hit && i_wdata[0]) begin
				done_q <= 1'b0;
			end else if (i_done) begin
				done_q <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/rsa_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rsa_defines.svh"

module rsa_top import rsa_pkg::*; (
	input  wire logic                       i_clk,
	input  wire logic                       i_rst,
	input  wire logic                       i_awvalid,
	output logic                            o_awready,
	input  wire logic [`AXIL_ADDR_W-1:0]    i_awaddr,
	input  wire logic                       i_wvalid,
	output logic                            o_wready,
	input  wire logic [`AXIL_DATA_W-1:0]    i_wdata,
	input  wire logic [`AXIL_DATA_W/8-1:0]  i_wstrb,
	output logic                            o_bvalid,
	input  wire logic                       i_bready,
	output axil_resp_t                      o_bresp,
	input  wire logic                       i_arvalid,
	output logic                            o_arready,
	input  wire logic [`AXIL_ADDR_W-1:0]    i_araddr,
	output logic                            o_rvalid,
	input  wire logic                       i_rready,
	output logic [`AXIL_DATA_W-1:0]         o_rdata,
	output axil_resp_t                      o_rresp
);
	logic      core_start;
	logic      core_busy;
	logic      core_done;
	rsa_word_t core_a;
	rsa_word_t core_d;
	rsa_word_t core_n;
	rsa_word_t core_result;

	rsa_axil_regs u_regs (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_awvalid (i_awvalid),
		.o_awready (o_awready),
		.i_awaddr  (i_awaddr),
		.i_wvalid  (i_wvalid),
		.o_wready  (o_wready),
		.i_wdata   (i_wdata),
		.i_wstrb   (i_wstrb),
		.o_bvalid  (o_bvalid),
		.i_bready  (i_bready),
		.o_bresp   (o_bresp),
		.i_arvalid (i_arvalid),
		.o_arready (o_arready),
		.i_araddr  (i_araddr),
		.o_rvalid  (o_rvalid),
		.i_rready  (i_rready),
		.o_rdata   (o_rdata),
		.o_rresp   (o_rresp),
		.o_start   (core_start),
		.o_a       (core_a),
		.o_d       (core_d),
		.o_n       (core_n),
		.i_busy    (core_busy),
		.i_done    (core_done),
		.i_result  (core_result)
	);

	rsa_core u_core (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (core_start),
		.i_a      (core_a),
		.i_d      (core_d),
		.i_n      (core_n),
		.o_result (core_result),
		.o_busy   (core_busy),
		.o_done   (core_done)
	);

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS  = 20,
	parameter int RST_CYCLES = 10
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	initial begin
		o_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge o_clk);
		o_rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== tests/tb_rsa_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rsa_defines.svh"

module tb_rsa_top import rsa_pkg::*; ;
	localparam int CLK_NS    = 20;
	localparam int CORE_LAT  = 1 + (`RSA_WIDTH + 1) + `RSA_WIDTH * (`RSA_WIDTH + 2);
	localparam int NUM_RUNS  = 9;
	localparam int POLL_GAP  = 64;
	localparam int MAX_POLLS = 2 * CORE_LAT / POLL_GAP;
	localparam longint WATCHDOG_NS = 2 * NUM_RUNS * CORE_LAT * CLK_NS + 200000;

	logic                      clk;
	logic                      rst;
	logic                      awvalid;
	logic                      awready;
	logic [`AXIL_ADDR_W-1:0]   awaddr;
	logic                      wvalid;
	logic                      wready;
	logic [`AXIL_DATA_W-1:0]   wdata;
	logic [`AXIL_DATA_W/8-1:0] wstrb;
	logic                      bvalid;
	logic                      bready;
	axil_resp_t                bresp;
	logic                      arvalid;
	logic                      arready;
	logic [`AXIL_ADDR_W-1:0]   araddr;
	logic                      rvalid;
	logic                      rready;
	logic [`AXIL_DATA_W-1:0]   rdata;
	axil_resp_t                rresp;

	int word_errs;
	int resp_errs;
	int status_errs;
	int other_errs;

	tb_clock #(.PERIOD_NS(CLK_NS), .RST_CYCLES(10)) u_clock (
		.o_clk (clk),
		.o_rst (rst)
	);

	rsa_top i_rsa_top (
		.i_clk     (clk),
		.i_rst     (rst),
		.i_awvalid (awvalid),
		.o_awready (awready),
		.i_awaddr  (awaddr),
		.i_wvalid  (wvalid),
		.o_wready  (wready),
		.i_wdata   (wdata),
		.i_wstrb   (wstrb),
		.o_bvalid  (bvalid),
		.i_bready  (bready),
		.o_bresp   (bresp),
		.i_arvalid (arvalid),
		.o_arready (arready),
		.i_araddr  (araddr),
		.o_rvalid  (rvalid),
		.i_rready  (rready),
		.o_rdata   (rdata),
		.o_rresp   (rresp)
	);

	// square-and-multiply on double-width intermediates
	function automatic rsa_word_t mod_exp(input rsa_word_t a, input rsa_word_t d,
		input rsa_word_t n);
		logic [2*`RSA_WIDTH-1:0] r;
		logic [2*`RSA_WIDTH-1:0] b;
		logic [2*`RSA_WIDTH-1:0] m;
		m = {{`RSA_WIDTH{1'b0}}, n};
		r = 1 % m;
		b = {{`RSA_WIDTH{1'b0}}, a} % m;
		for (int i = 0; i < `RSA_WIDTH; i++) begin
			if (d[i]) begin
				r = (r * b) % m;
			end
			b = (b * b) % m;
		end
		return r[`RSA_WIDTH-1:0];
	endfunction

	function automatic rsa_word_t rand_word();
		rsa_word_t w;
		for (int i = 0; i < `RSA_WIDTH / 32; i++) begin
			w[32*i +: 32] = $urandom;
		end
		return w;
	endfunction

	task automatic check_word(input string name, input rsa_word_t exp, input rsa_word_t act);
		if (act !== exp) begin
			word_errs++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
		if (act !== exp) begin
			resp_errs++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			status_errs++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic axi_write(input logic [`AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int bdelay, output axil_resp_t resp);
		@(posedge clk);
		awvalid <= 1'b1;
		awaddr  <= addr;
		wvalid  <= 1'b1;
		wdata   <= data;
		wstrb   <= strb;
		@(negedge clk);
		while (!(awready && wready)) begin
			@(negedge clk);
		end
		// handshake edge
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		awaddr  <= ~addr;
		repeat (bdelay) begin
			@(negedge clk);
			if (!bvalid) begin
				other_errs++;
				$display("bvalid dropped before bready was raised at %0t", $time);
			end
		end
		@(posedge clk);
		bready <= 1'b1;
		@(negedge clk);
		while (!bvalid) begin
			@(negedge clk);
		end
		resp = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [`AXIL_ADDR_W-1:0] addr, input int rdelay,
		output logic [31:0] data, output axil_resp_t resp);
		@(posedge clk);
		arvalid <= 1'b1;
		araddr  <= addr;
		@(negedge clk);
		while (!arready) begin
			@(negedge clk);
		end
		@(posedge clk);
		arvalid <= 1'b0;
		araddr  <= ~addr;
		@(negedge clk);
		while (!rvalid) begin
			@(negedge clk);
		end
		data = rdata;
		resp = rresp;
		// payload must hold while rready stays low
		repeat (rdelay) begin
			@(negedge clk);
			if (!rvalid) begin
				other_errs++;
				$display("rvalid dropped before rready was raised at %0t", $time);
			end
			check_status("rdata held", data, rdata);
		end
		@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic write_operand(input logic [`AXIL_ADDR_W-1:0] base, input rsa_word_t val);
		axil_resp_t resp;
		for (int i = 0; i < `RSA_WIDTH / 32; i++) begin
			axi_write(base + 4 * i, val[32*i +: 32], 4'hf, 0, resp);
			check_resp("bresp", RESP_OKAY, resp);
		end
	endtask

	task automatic read_operand(input logic [`AXIL_ADDR_W-1:0] base, output rsa_word_t val);
		axil_resp_t  resp;
		logic [31:0] data;
		for (int i = 0; i < `RSA_WIDTH / 32; i++) begin
			axi_read(base + 4 * i, 0, data, resp);
			check_resp("rresp", RESP_OKAY, resp);
			val[32*i +: 32] = data;
		end
	endtask

	task automatic start_core();
		axil_resp_t resp;
		axi_write(`RSA_REG_CTRL, 32'h1, 4'hf, 0, resp);
		check_resp("bresp ctrl", RESP_OKAY, resp);
	endtask

	task automatic wait_done();
		logic [31:0] st;
		axil_resp_t  resp;
		int          polls;
		st    = '0;
		polls = 0;
		while (!st[1] && polls < MAX_POLLS) begin
			repeat (POLL_GAP) @(posedge clk);
			axi_read(`RSA_REG_STATUS, 0, st, resp);
			polls++;
		end
		if (!st[1]) begin
			other_errs++;
			$display("done bit never set after %0d status polls", polls);
		end
	endtask

	task automatic random_operands(output rsa_word_t a, output rsa_word_t d,
		output rsa_word_t n);
		n = rand_word();
		n[`RSA_WIDTH-1] = 1'b1;
		n[0] = 1'b1;
		// top bit clear keeps A below N
		a = rand_word();
		a[`RSA_WIDTH-1] = 1'b0;
		d = rand_word();
	endtask

	task automatic run_exp(input rsa_word_t a, input rsa_word_t d, input rsa_word_t n,
		output rsa_word_t res);
		write_operand(`RSA_REG_A, a);
		write_operand(`RSA_REG_D, d);
		write_operand(`RSA_REG_N, n);
		start_core();
		wait_done();
		read_operand(`RSA_REG_RESULT, res);
	endtask

	task automatic test_reset();
		logic [31:0] st;
		axil_resp_t  resp;
		rsa_word_t   val;
		axi_read(`RSA_REG_STATUS, 0, st, resp);
		check_resp("rresp status", RESP_OKAY, resp);
		check_status("status", 32'h0, st);
		read_operand(`RSA_REG_RESULT, val);
		check_word("result", '0, val);
		read_operand(`RSA_REG_A, val);
		check_word("a", '0, val);
		read_operand(`RSA_REG_D, val);
		check_word("d", '0, val);
		read_operand(`RSA_REG_N, val);
		check_word("n", '0, val);
	endtask

	task automatic check_vector(input rsa_word_t a, input rsa_word_t d, input rsa_word_t n,
		input rsa_word_t known);
		rsa_word_t res;
		rsa_word_t model;
		model = mod_exp(a, d, n);
		check_word("model", known, model);
		run_exp(a, d, n, res);
		check_word("result", model, res);
	endtask

	task automatic test_known();
		check_vector(256'd5, 256'd1, 256'd13, 256'd5);
		check_vector(256'd7, 256'd0, 256'd13, 256'd1);
		check_vector(256'd4, 256'd13, 256'd497, 256'd445);
	endtask

	task automatic test_random();
		rsa_word_t a;
		rsa_word_t d;
		rsa_word_t n;
		rsa_word_t res;
		repeat (3) begin
			random_operands(a, d, n);
			run_exp(a, d, n, res);
			check_word("result", mod_exp(a, d, n), res);
		end
	endtask

	task automatic test_busy_writes();
		rsa_word_t   a;
		rsa_word_t   d;
		rsa_word_t   n;
		rsa_word_t   val;
		logic [31:0] st;
		axil_resp_t  resp;
		random_operands(a, d, n);
		write_operand(`RSA_REG_A, a);
		write_operand(`RSA_REG_D, d);
		write_operand(`RSA_REG_N, n);
		start_core();
		axi_read(`RSA_REG_STATUS, 0, st, resp);
		check_status("status busy", 32'h1, st);
		axi_write(`RSA_REG_CTRL, 32'h1, 4'hf, 0, resp);
		check_resp("bresp ctrl busy", RESP_SLVERR, resp);
		axi_write(`RSA_REG_N, ~n[31:0], 4'hf, 0, resp);
		check_resp("bresp n busy", RESP_SLVERR, resp);
		wait_done();
		read_operand(`RSA_REG_RESULT, val);
		check_word("result", mod_exp(a, d, n), val);
		read_operand(`RSA_REG_N, val);
		check_word("n", n, val);
	endtask

	task automatic test_axi_corners();
		logic [31:0] data;
		axil_resp_t  resp;
		axi_read(8'h08, 0, data, resp);
		check_resp("rresp unmapped", RESP_SLVERR, resp);
		check_status("rdata unmapped", 32'h0, data);
		axi_read(8'ha0, 0, data, resp);
		check_resp("rresp unmapped", RESP_SLVERR, resp);
		check_status("rdata unmapped", 32'h0, data);
		axi_write(`RSA_REG_A, 32'h1234_5678, 4'hf, 5, resp);
		check_resp("bresp delayed", RESP_OKAY, resp);
		axi_read(`RSA_REG_A, 6, data, resp);
		check_resp("rresp delayed", RESP_OKAY, resp);
		check_status("rdata a0", 32'h1234_5678, data);
		// bytes 0 and 2 only
		axi_write(`RSA_REG_A, 32'haabb_ccdd, 4'b0101, 0, resp);
		check_resp("bresp strobed", RESP_OKAY, resp);
		axi_read(`RSA_REG_A, 0, data, resp);
		check_resp("rresp strobed", RESP_OKAY, resp);
		check_status("rdata a0 strobed", 32'h12bb_56dd, data);
	endtask

	task automatic test_done_sticky();
		rsa_word_t   a;
		rsa_word_t   d;
		rsa_word_t   n;
		rsa_word_t   res;
		logic [31:0] st;
		axil_resp_t  resp;
		random_operands(a, d, n);
		run_exp(a, d, n, res);
		check_word("result", mod_exp(a, d, n), res);
		repeat (2) begin
			axi_read(`RSA_REG_STATUS, 0, st, resp);
			check_status("status done", 32'h2, st);
		end
		start_core();
		axi_read(`RSA_REG_STATUS, 0, st, resp);
		check_status("status restart", 32'h1, st);
		wait_done();
		read_operand(`RSA_REG_RESULT, res);
		check_word("result", mod_exp(a, d, n), res);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int total;
		void'($urandom(87301));
		word_errs   = 0;
		resp_errs   = 0;
		status_errs = 0;
		other_errs  = 0;
		awvalid <= 1'b0;
		awaddr  <= '0;
		wvalid  <= 1'b0;
		wdata   <= '0;
		wstrb   <= '0;
		bready  <= 1'b0;
		arvalid <= 1'b0;
		araddr  <= '0;
		rready  <= 1'b0;
		wait (rst == 1'b0);
		@(posedge clk);
		test_reset();
		test_known();
		test_random();
		test_busy_writes();
		test_axi_corners();
		test_done_sticky();
		total = word_errs + resp_errs + status_errs + other_errs;
		$display("errors: word %0d, resp %0d, status %0d, other %0d",
			word_errs, resp_errs, status_errs, other_errs);
		if (total == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
logic/rsa_pkg.sv
logic/rsa_prescale.sv
logic/rsa_mont_mult.sv
logic/rsa_core.sv
logic/rsa_axil_regs.sv
logic/rsa_top.sv
tests/tb_clock.sv
tests/tb_rsa_top.sv

// ==== Bender.yml ====
package:
  name: rsa_modexp

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - logic/rsa_pkg.sv
      - logic/rsa_prescale.sv
      - logic/rsa_mont_mult.sv
      - logic/rsa_core.sv
      - logic/rsa_axil_regs.sv
      - logic/rsa_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tests/tb_clock.sv
      - tests/tb_rsa_top.sv
